// File: hw/bp_defines.svh
`ifndef BP_DEFINES_SVH
`define BP_DEFINES_SVH

// Circular global history buffer
`define GHIST_SIZE      64
`define GHIST_WIDTH     6

`define TAGE_BANK       2

// Fold widths per bank
`define FOLD_IDX_WIDTH  8
`define FOLD_TAG_WIDTH  7

// History length seen by each bank
`define HIST_LEN_0      13
`define HIST_LEN_1      32

`define SC_GHIST_WIDTH  16

// Bank b sits at [b*FOLD_BANK_WIDTH +: FOLD_BANK_WIDTH]
// Index fold in the low bits, tag fold above it
`define FOLD_BANK_WIDTH (`FOLD_IDX_WIDTH + `FOLD_TAG_WIDTH)
`define FOLD_BUS_WIDTH  (`FOLD_BANK_WIDTH * `TAGE_BANK)

`endif

// File: hw/bp_pkg.sv
`default_nettype none

package bp_pkg;

    // Conditional branches in one fetch block
    // Only 0, 1 and 2 are legal
    typedef logic [1:0] cond_cnt_t;

    // Which kind of update the history store applies this cycle
    typedef enum logic [1:0] {
        UPD_NONE   = 2'd0,
        UPD_PRED   = 2'd1, // Speculative append
        UPD_SQUASH = 2'd2  // Checkpoint restore, then append
    } upd_src_e;

endpackage

`default_nettype wire

// File: hw/fold_history.sv
`timescale 1ns/1ps
`default_nettype none

module fold_history import bp_pkg::*; #(
    parameter int FOLD_WIDTH = 8,
    parameter int ORIG_LEN   = 13
) (
    input  logic [FOLD_WIDTH-1:0] origin,
    input  cond_cnt_t             cond_num,
    input  logic                  dir,
    input  logic [1:0]            evict_dir, // [0] is the older bit
    output logic [FOLD_WIDTH-1:0] fold
);

generate
    if (ORIG_LEN < FOLD_WIDTH) begin : g_shift
        // Window fits in the fold, nothing wraps around
        localparam logic [FOLD_WIDTH-1:0] ONE = FOLD_WIDTH'(1);
        localparam logic [FOLD_WIDTH-1:0] LEN_MASK = (ONE << ORIG_LEN) - ONE;

        always_comb begin
            case (cond_num)
                2'd1: fold = ((origin << 1) | FOLD_WIDTH'(dir)) & LEN_MASK;
                2'd2: fold = ((origin << 2) | FOLD_WIDTH'(dir)) & LEN_MASK;
                default: fold = origin;
            endcase
        end
    end else begin : g_rotate
        localparam int POS_AGE_L  = ORIG_LEN % FOLD_WIDTH;       // Age ORIG_LEN lands here
        localparam int POS_AGE_L1 = (ORIG_LEN + 1) % FOLD_WIDTH;
        logic [FOLD_WIDTH-1:0] rot1;
        logic [FOLD_WIDTH-1:0] rot2;

        assign rot1 = {origin[FOLD_WIDTH-2:0], origin[FOLD_WIDTH-1]};
        assign rot2 = {rot1[FOLD_WIDTH-2:0], rot1[FOLD_WIDTH-1]};

        always_comb begin
            fold = origin;
            if (cond_num == 2'd1) begin
                fold = rot1 ^ FOLD_WIDTH'(dir);
                fold[POS_AGE_L] = fold[POS_AGE_L] ^ evict_dir[0];
            end else if (cond_num == 2'd2) begin
                // Two appends, so the older evicted bit moved one place further
                fold = rot2 ^ FOLD_WIDTH'(dir);
                fold[POS_AGE_L] = fold[POS_AGE_L] ^ evict_dir[1];
                fold[POS_AGE_L1] = fold[POS_AGE_L1] ^ evict_dir[0];
            end
        end
    end
endgenerate

endmodule

`default_nettype wire

// File: hw/hist_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defines.svh"

module hist_arbiter import bp_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pred_req,
    input  cond_cnt_t                   pred_cond_num,
    input  logic                        pred_taken,
    input  logic                        squash_req,
    input  cond_cnt_t                   squash_cond_num,
    input  logic                        squash_taken,
    input  logic [`GHIST_WIDTH-1:0]     squash_ghist_idx,
    input  logic [`FOLD_BUS_WIDTH-1:0]  squash_fold,
    input  logic [`SC_GHIST_WIDTH-1:0]  squash_sc_ghist,
    output logic                        pred_ack,
    output logic                        squash_ack,
    output upd_src_e                    upd_src,
    output cond_cnt_t                   upd_cond_num,
    output logic                        upd_taken,
    output logic [`GHIST_WIDTH-1:0]     upd_ghist_idx,
    output logic [`FOLD_BUS_WIDTH-1:0]  upd_fold,
    output logic [`SC_GHIST_WIDTH-1:0]  upd_sc_ghist
);
    localparam int PORT_PRED   = 0;
    localparam int PORT_SQUASH = 1;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_APPLY = 2'd1; // upd_src is out this cycle
    localparam logic [1:0] ST_ACKED = 2'd2; // Waiting for req to drop

    logic [1:0] port_st [2];
    logic [1:0] req;
    logic [1:0] grant;
    logic       bus_free;

    assign req = {squash_req, pred_req};

    // A new grant waits until the other handshake has fully closed
    assign bus_free = (port_st[PORT_PRED] == ST_IDLE) && (port_st[PORT_SQUASH] == ST_IDLE);
    assign grant[PORT_SQUASH] = bus_free & squash_req;
    assign grant[PORT_PRED]   = bus_free & pred_req & ~squash_req;

    assign pred_ack   = port_st[PORT_PRED] == ST_ACKED;
    assign squash_ack = port_st[PORT_SQUASH] == ST_ACKED;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            port_st[PORT_PRED] <= ST_IDLE;
            port_st[PORT_SQUASH] <= ST_IDLE;
            upd_src <= UPD_NONE;
        end else begin
            for (int i = 0; i < 2; i++) begin
                case (port_st[i])
                    ST_IDLE:  if (grant[i]) port_st[i] <= ST_APPLY;
                    ST_APPLY: port_st[i] <= ST_ACKED;
                    ST_ACKED: if (!req[i]) port_st[i] <= ST_IDLE;
                    default:  port_st[i] <= ST_IDLE;
                endcase
            end
            if (grant[PORT_SQUASH]) begin
                upd_src <= UPD_SQUASH;
            end else if (grant[PORT_PRED]) begin
                upd_src <= UPD_PRED;
            end else begin
                upd_src <= UPD_NONE;
            end
        end
    end

    // Winner's data held for the apply cycle
    always_ff @(posedge clk) begin
        if (grant[PORT_SQUASH]) begin
            upd_cond_num <= squash_cond_num;
            upd_taken <= squash_taken;
            upd_ghist_idx <= squash_ghist_idx;
            upd_fold <= squash_fold;
            upd_sc_ghist <= squash_sc_ghist;
        end else if (grant[PORT_PRED]) begin
            upd_cond_num <= pred_cond_num;
            upd_taken <= pred_taken;
        end
    end

    ack_exclusive: assert property (@(posedge clk) disable iff (!rst)
        !(pred_ack && squash_ack))
        else $error("pred_ack and squash_ack high together");

    pred_ack_rise: assert property (@(posedge clk) disable iff (!rst)
        $rose(pred_ack) |-> pred_req)
        else $error("pred_ack rose without pred_req");

    squash_ack_rise: assert property (@(posedge clk) disable iff (!rst)
        $rose(squash_ack) |-> squash_req)
        else $error("squash_ack rose without squash_req");

    cond_num_legal: assert property (@(posedge clk) disable iff (!rst)
        (!pred_req || pred_cond_num != 2'd3) && (!squash_req || squash_cond_num != 2'd3))
        else $error("cond_num of 3 on a request");

endmodule

`default_nettype wire

// File: hw/history_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defines.svh"

module history_ctrl import bp_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  upd_src_e                    upd_src,
    input  cond_cnt_t                   upd_cond_num,
    input  logic                        upd_taken,
    input  logic [`GHIST_WIDTH-1:0]     upd_ghist_idx,
    input  logic [`FOLD_BUS_WIDTH-1:0]  upd_fold,
    input  logic [`SC_GHIST_WIDTH-1:0]  upd_sc_ghist,
    output logic [`GHIST_WIDTH-1:0]     ghist_idx,
    output logic [`FOLD_BUS_WIDTH-1:0]  fold_out,
    output logic [`SC_GHIST_WIDTH-1:0]  sc_ghist
);
    localparam int IDX_W  = `GHIST_WIDTH;
    localparam int SC_W   = `SC_GHIST_WIDTH;
    localparam int IDX_FW = `FOLD_IDX_WIDTH;
    localparam int TAG_FW = `FOLD_TAG_WIDTH;
    localparam int BANK_W = `FOLD_BANK_WIDTH;
    localparam int HIST_LEN [`TAGE_BANK] = '{`HIST_LEN_0, `HIST_LEN_1};

    logic [`GHIST_SIZE-1:0]     ghist;
    logic                       upd_en;
    logic                       squash;
    logic [IDX_W-1:0]           base_idx;
    logic [IDX_W-1:0]           base_idx_n;
    logic [IDX_W-1:0]           next_idx;
    logic [`FOLD_BUS_WIDTH-1:0] base_fold;
    logic [`FOLD_BUS_WIDTH-1:0] next_fold;
    logic [SC_W-1:0]            base_sc;
    logic [SC_W-1:0]            next_sc;

    assign upd_en = upd_src != UPD_NONE;
    assign squash = upd_src == UPD_SQUASH;

    // Squash starts from the checkpoint, prediction from the live state
    assign base_idx  = squash ? upd_ghist_idx : ghist_idx;
    assign base_fold = squash ? upd_fold : fold_out;
    assign base_sc   = squash ? upd_sc_ghist : sc_ghist;

    assign base_idx_n = base_idx + IDX_W'(1);
    assign next_idx   = base_idx + IDX_W'(upd_cond_num); // Wraps modulo buffer size

    always_comb begin
        case (upd_cond_num)
            2'd1: next_sc = {base_sc[SC_W-2:0], upd_taken};
            2'd2: next_sc = {base_sc[SC_W-3:0], 1'b0, upd_taken};
            default: next_sc = base_sc;
        endcase
    end

    for (genvar b = 0; b < `TAGE_BANK; b++) begin : g_bank
        localparam int LEN = HIST_LEN[b];
        logic [IDX_W-1:0] evict_idx;
        logic [IDX_W-1:0] evict_idx_n;
        logic [1:0]       evict_dir;

        // Oldest bits of this bank's window, about to fall out
        assign evict_idx   = base_idx - IDX_W'(LEN);
        assign evict_idx_n = evict_idx + IDX_W'(1);
        assign evict_dir   = {ghist[evict_idx_n], ghist[evict_idx]};

        fold_history #(
            .FOLD_WIDTH (IDX_FW),
            .ORIG_LEN   (LEN)
        ) u_fold_idx (
            .origin    (base_fold[b*BANK_W +: IDX_FW]),
            .cond_num  (upd_cond_num),
            .dir       (upd_taken),
            .evict_dir (evict_dir),
            .fold      (next_fold[b*BANK_W +: IDX_FW])
        );

        fold_history #(
            .FOLD_WIDTH (TAG_FW),
            .ORIG_LEN   (LEN)
        ) u_fold_tag (
            .origin    (base_fold[b*BANK_W+IDX_FW +: TAG_FW]),
            .cond_num  (upd_cond_num),
            .dir       (upd_taken),
            .evict_dir (evict_dir),
            .fold      (next_fold[b*BANK_W+IDX_FW +: TAG_FW])
        );
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ghist <= '0;
            ghist_idx <= '0;
            fold_out <= '0;
            sc_ghist <= '0;
        end else if (upd_en) begin
            ghist_idx <= next_idx;
            fold_out <= next_fold;
            sc_ghist <= next_sc;
            if (upd_cond_num == 2'd1) begin
                ghist[base_idx] <= upd_taken;
            end else if (upd_cond_num == 2'd2) begin
                ghist[base_idx] <= 1'b0; // First branch fell through
                ghist[base_idx_n] <= upd_taken;
            end
        end
    end

    upd_cond_legal: assert property (@(posedge clk) disable iff (!rst)
        upd_en |-> upd_cond_num != 2'd3)
        else $error("update applied with cond_num 3");

endmodule

`default_nettype wire

// File: hw/history_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defines.svh"

module history_top import bp_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        pred_req,
    output logic                        pred_ack,
    input  cond_cnt_t                   pred_cond_num,
    input  logic                        pred_taken,
    input  logic                        squash_req,
    output logic                        squash_ack,
    input  cond_cnt_t                   squash_cond_num,
    input  logic                        squash_taken,
    input  logic [`GHIST_WIDTH-1:0]     squash_ghist_idx,
    input  logic [`FOLD_BUS_WIDTH-1:0]  squash_fold,
    input  logic [`SC_GHIST_WIDTH-1:0]  squash_sc_ghist,
    output logic [`GHIST_WIDTH-1:0]     ghist_idx,
    output logic [`FOLD_BUS_WIDTH-1:0]  fold_out,
    output logic [`SC_GHIST_WIDTH-1:0]  sc_ghist
);
    upd_src_e                   upd_src;
    cond_cnt_t                  upd_cond_num;
    logic                       upd_taken;
    logic [`GHIST_WIDTH-1:0]    upd_ghist_idx;
    logic [`FOLD_BUS_WIDTH-1:0] upd_fold;
    logic [`SC_GHIST_WIDTH-1:0] upd_sc_ghist;

    hist_arbiter u_arb (
        .clk              (clk),
        .rst              (rst),
        .pred_req         (pred_req),
        .pred_cond_num    (pred_cond_num),
        .pred_taken       (pred_taken),
        .squash_req       (squash_req),
        .squash_cond_num  (squash_cond_num),
        .squash_taken     (squash_taken),
        .squash_ghist_idx (squash_ghist_idx),
        .squash_fold      (squash_fold),
        .squash_sc_ghist  (squash_sc_ghist),
        .pred_ack         (pred_ack),
        .squash_ack       (squash_ack),
        .upd_src          (upd_src),
        .upd_cond_num     (upd_cond_num),
        .upd_taken        (upd_taken),
        .upd_ghist_idx    (upd_ghist_idx),
        .upd_fold         (upd_fold),
        .upd_sc_ghist     (upd_sc_ghist)
    );

    history_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .upd_src       (upd_src),
        .upd_cond_num  (upd_cond_num),
        .upd_taken     (upd_taken),
        .upd_ghist_idx (upd_ghist_idx),
        .upd_fold      (upd_fold),
        .upd_sc_ghist  (upd_sc_ghist),
        .ghist_idx     (ghist_idx),
        .fold_out      (fold_out),
        .sc_ghist      (sc_ghist)
    );

endmodule

`default_nettype wire

// File: tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
end

initial begin
    rst = 1'b0; // Active low
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b1;
end

endmodule

`default_nettype wire

// File: tests/tb_history.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_defines.svh"

module tb_history import bp_pkg::*; ;

    localparam int PW              = `GHIST_WIDTH;
    localparam int N_RANDOM        = 80; // Enough blocks to wrap the pointer
    localparam int N_OPS           = N_RANDOM + 24;
    localparam int WATCHDOG_CYCLES = N_OPS * 20 + 100;
    localparam int ACK_LIMIT       = 40;

    logic                       clk;
    logic                       rst;
    logic                       pred_req;
    logic                       pred_ack;
    cond_cnt_t                  pred_cond_num;
    logic                       pred_taken;
    logic                       squash_req;
    logic                       squash_ack;
    cond_cnt_t                  squash_cond_num;
    logic                       squash_taken;
    logic [PW-1:0]              squash_ghist_idx;
    logic [`FOLD_BUS_WIDTH-1:0] squash_fold;
    logic [`SC_GHIST_WIDTH-1:0] squash_sc_ghist;
    logic [PW-1:0]              ghist_idx;
    logic [`FOLD_BUS_WIDTH-1:0] fold_out;
    logic [`SC_GHIST_WIDTH-1:0] sc_ghist;

    integer                     seed;
    int                         errors;
    int                         checks;
    logic [`GHIST_SIZE-1:0]     mh; // Reference history buffer
    logic [PW-1:0]              m_ptr;
    logic [`SC_GHIST_WIDTH-1:0] m_sc;
    logic [PW-1:0]              snap_ptr;
    logic [`SC_GHIST_WIDTH-1:0] snap_sc;
    logic [`FOLD_BUS_WIDTH-1:0] snap_fold;

    tb_clock u_clock (.clk(clk), .rst(rst));

    history_top u_history_top (
        .clk(clk), .rst(rst),
        .pred_req(pred_req), .pred_ack(pred_ack),
        .pred_cond_num(pred_cond_num), .pred_taken(pred_taken),
        .squash_req(squash_req), .squash_ack(squash_ack),
        .squash_cond_num(squash_cond_num), .squash_taken(squash_taken),
        .squash_ghist_idx(squash_ghist_idx), .squash_fold(squash_fold),
        .squash_sc_ghist(squash_sc_ghist),
        .ghist_idx(ghist_idx), .fold_out(fold_out), .sc_ghist(sc_ghist)
    );

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
        end
    endtask

    function automatic logic hist_bit_at_age(input int age);
        logic [PW-1:0] pos;
        pos = m_ptr - PW'(1) - PW'(age); // Age 0 is the newest bit
        return mh[pos];
    endfunction

    function automatic logic [`FOLD_BANK_WIDTH-1:0] bank_fold(input int len);
        logic [`FOLD_IDX_WIDTH-1:0] fi;
        logic [`FOLD_TAG_WIDTH-1:0] ft;
        logic                       b;
        fi = '0;
        ft = '0;
        for (int k = 0; k < len; k++) begin
            b = hist_bit_at_age(k);
            fi = fi ^ (`FOLD_IDX_WIDTH'(b) << (k % `FOLD_IDX_WIDTH));
            ft = ft ^ (`FOLD_TAG_WIDTH'(b) << (k % `FOLD_TAG_WIDTH));
        end
        return {ft, fi};
    endfunction

    function automatic logic [`FOLD_BUS_WIDTH-1:0] expected_fold();
        return {bank_fold(`HIST_LEN_1), bank_fold(`HIST_LEN_0)};
    endfunction

    task automatic push_bit(input logic b);
        mh[m_ptr] = b;
        m_ptr = m_ptr + PW'(1);
        m_sc = {m_sc[`SC_GHIST_WIDTH-2:0], b};
    endtask

    task automatic model_append(input cond_cnt_t cond, input logic taken);
        if (cond == 2'd2) push_bit(1'b0); // First branch not taken
        if (cond != 2'd0) push_bit(taken);
    endtask

    task automatic take_snapshot();
        snap_ptr = m_ptr;
        snap_sc = m_sc;
        snap_fold = expected_fold();
    endtask

    task automatic check_outputs();
        check_value("ghist_idx", 64'(m_ptr), 64'(ghist_idx));
        check_value("fold_out", 64'(expected_fold()), 64'(fold_out));
        check_value("sc_ghist", 64'(m_sc), 64'(sc_ghist));
    endtask

    // Samples on falling edges, away from the driving edge
    task automatic wait_ack(input logic on_squash, input logic level, output int cycles);
        logic done;
        cycles = 0;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if ((on_squash ? squash_ack : pred_ack) == level) begin
                done = 1'b1;
            end else if (cycles >= ACK_LIMIT) begin
                errors++;
                $display("%s did not reach %0b within %0d cycles",
                         on_squash ? "squash_ack" : "pred_ack", level, ACK_LIMIT);
                done = 1'b1;
            end
        end
    endtask

    task automatic send_pred(input cond_cnt_t cond, input logic taken, output int lat);
        int drop;
        @(posedge clk);
        pred_req <= 1'b1;
        pred_cond_num <= cond;
        pred_taken <= taken;
        wait_ack(1'b0, 1'b1, lat);
        model_append(cond, taken);
        check_outputs();
        @(posedge clk);
        pred_req <= 1'b0;
        wait_ack(1'b0, 1'b0, drop);
    endtask

    task automatic send_random_pred();
        logic [31:0] rnd;
        int          lat;
        rnd = $random(seed);
        send_pred(rnd[1] ? 2'd2 : 2'd1, rnd[0], lat);
    endtask

    task automatic drive_squash(input cond_cnt_t cond, input logic taken);
        squash_req <= 1'b1;
        squash_cond_num <= cond;
        squash_taken <= taken;
        squash_ghist_idx <= snap_ptr;
        squash_fold <= snap_fold;
        squash_sc_ghist <= snap_sc;
    endtask

    task automatic check_after_reset();
        check_value("pred_ack", 64'd0, 64'(pred_ack));
        check_value("squash_ack", 64'd0, 64'(squash_ack));
        check_outputs();
    endtask

    task automatic run_single_preds();
        int lat;
        send_pred(2'd1, 1'b1, lat);
        check_value("pred_ack latency", 64'd3, 64'(lat)); // Two edges after req is sampled
        send_pred(2'd2, 1'b1, lat);
        send_pred(2'd2, 1'b0, lat);
        send_pred(2'd1, 1'b0, lat);
    endtask

    task automatic run_random_stream();
        for (int i = 0; i < N_RANDOM; i++) send_random_pred();
    endtask

    task automatic restore_from_squash();
        int lat;
        int drop;
        take_snapshot();
        repeat (6) send_random_pred(); // Wrong path
        @(posedge clk);
        drive_squash(2'd2, 1'b1);
        wait_ack(1'b1, 1'b1, lat);
        m_ptr = snap_ptr;
        m_sc = snap_sc;
        model_append(2'd2, 1'b1);
        check_outputs();
        @(posedge clk);
        squash_req <= 1'b0;
        wait_ack(1'b1, 1'b0, drop);
    endtask

    task automatic race_both_ports();
        int lat;
        int drop;
        take_snapshot();
        repeat (4) send_random_pred();
        @(posedge clk);
        pred_req <= 1'b1;
        pred_cond_num <= 2'd2;
        pred_taken <= 1'b1;
        drive_squash(2'd1, 1'b0);
        wait_ack(1'b1, 1'b1, lat);
        check_value("pred_ack", 64'd0, 64'(pred_ack)); // Squash must win
        m_ptr = snap_ptr;
        m_sc = snap_sc;
        model_append(2'd1, 1'b0);
        check_outputs();
        @(posedge clk);
        squash_req <= 1'b0;
        wait_ack(1'b0, 1'b1, lat);
        model_append(2'd2, 1'b1);
        check_outputs();
        @(posedge clk);
        pred_req <= 1'b0;
        wait_ack(1'b0, 1'b0, drop);
    endtask

    task automatic empty_block_pred();
        int lat;
        send_pred(2'd0, 1'b1, lat);
    endtask

    initial begin
        pred_req = 1'b0;
        pred_cond_num = 2'd0;
        pred_taken = 1'b0;
        squash_req = 1'b0;
        squash_cond_num = 2'd0;
        squash_taken = 1'b0;
        squash_ghist_idx = '0;
        squash_fold = '0;
        squash_sc_ghist = '0;
        seed = 32'h3874_e5c0;
        errors = 0;
        checks = 0;
        mh = '0;
        m_ptr = '0;
        m_sc = '0;
        @(posedge rst);
        @(negedge clk);
        check_after_reset();
        run_single_preds();
        run_random_stream();
        restore_from_squash();
        race_both_ports();
        empty_block_pred();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/bp_pkg.sv
hw/fold_history.sv
hw/hist_arbiter.sv
hw/history_ctrl.sv
hw/history_top.sv
tests/tb_clock.sv
tests/tb_history.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the history testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_history -o tb_history
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_history)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found"
exit 1
